// ==== arm_pkg.sv ====
package arm_pkg;

	////////////////////////////////////////
	// Architectural constants
	////////////////////////////////////////

	localparam int word_w = 32;             // Data path width.

	// Register 15 is the program counter.
	localparam logic [3:0] reg_pc = 4'd15;

	localparam int cpsr_c_bit = 29;         // Carry flag position.

	////////////////////////////////////////
	// Instruction classes
	////////////////////////////////////////

	// Handed to the execute stage with the operands.
	typedef enum logic [2:0] {
		class_data   = 3'd0,  // Data processing.
		class_mul    = 3'd1,  // Multiply and multiply-accumulate.
		class_sdt    = 3'd2,  // Single data transfer.
		class_bdt    = 3'd3,  // Block data transfer.
		class_branch = 3'd4,  // Branch and branch with link.
		class_other  = 3'd5   // PSR transfer, swap, halfword, coprocessor, SWI.
	} insn_class_t;

	////////////////////////////////////////
	// Shift types
	////////////////////////////////////////

	// Encoding of instruction bits 6:5.
	typedef enum logic [1:0] {
		shift_lsl = 2'd0,
		shift_lsr = 2'd1,
		shift_asr = 2'd2,
		shift_ror = 2'd3      // RRX when the immediate amount is zero.
	} shift_type_t;

endpackage

// ==== barrel_shifter.sv ====
`timescale 1ns/1ps

module barrel_shifter (
	input  logic [arm_pkg::word_w-1:0] operand,
	input  logic [7:0]                 reg_amount,
	input  logic [4:0]                 imm_amount,
	input  logic                       by_register,
	input  arm_pkg::shift_type_t       shift_type,
	input  logic                       carry_in,
	output logic [arm_pkg::word_w-1:0] result,
	output logic                       carry_out
);
	import arm_pkg::*;

	logic [7:0]        amount;     // Effective shift amount.
	logic              no_shift;
	logic [4:0]        rot;
	logic [word_w-1:0] rotated;
	logic [word_w:0]   lsl_vec;    // {carry, result}
	logic [word_w:0]   lsr_vec;    // {result, carry}
	logic signed [word_w:0] asr_vec;

	// Immediate zero means 32 for the right shifts.
	always_comb begin
		amount = by_register ? reg_amount : {3'b000, imm_amount};
		if (!by_register && imm_amount == 5'd0 &&
		    (shift_type == shift_lsr || shift_type == shift_asr)) begin
			amount = 8'd32;
		end
	end

	// Register amount 0 and LSL #0 pass straight through; ROR #0 is RRX.
	assign no_shift = (amount == 8'd0) && (by_register || shift_type != shift_ror);

	////////////////////////////////////////
	// Shift paths
	////////////////////////////////////////

	// Amounts of 33 and up shift everything out, carry included.
	assign lsl_vec = {1'b0, operand} << amount;
	assign lsr_vec = {operand, 1'b0} >> amount;
	assign asr_vec = $signed({operand, 1'b0}) >>> amount;

	assign rot     = amount[4:0];
	assign rotated = (operand >> rot) | (operand << (6'd32 - {1'b0, rot}));

	always_comb begin
		result    = operand;
		carry_out = carry_in;
		if (!no_shift) begin
			case (shift_type)
				shift_lsl: begin
					{carry_out, result} = lsl_vec;
				end
				shift_lsr: begin
					{result, carry_out} = lsr_vec;
				end
				shift_asr: begin
					{result, carry_out} = asr_vec;
				end
				default: begin
					if (!by_register && imm_amount == 5'd0) begin
						result    = {carry_in, operand[word_w-1:1]};  // RRX.
						carry_out = operand[0];
					end else begin
						result    = rotated;
						carry_out = rotated[word_w-1];  // Last bit rotated out.
					end
				end
			endcase
		end
	end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       we,
	input  logic [3:0]                 waddr,
	input  logic [arm_pkg::word_w-1:0] wdata,
	input  logic [3:0]                 sel0,
	input  logic [3:0]                 sel1,
	input  logic [3:0]                 sel2,
	output logic [arm_pkg::word_w-1:0] rdata0,
	output logic [arm_pkg::word_w-1:0] rdata1,
	output logic [arm_pkg::word_w-1:0] rdata2
);
	import arm_pkg::*;

	// General registers r0 to r14, the PC lives elsewhere.
	logic [word_w-1:0] regs [0:reg_pc-1];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_pc; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != reg_pc) begin
			regs[waddr] <= wdata;  // Writes to r15 dropped.
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// r15 reads zero here. Decoder inserts the PC.
	assign rdata0 = (sel0 == reg_pc) ? '0 : regs[sel0];
	assign rdata1 = (sel1 == reg_pc) ? '0 : regs[sel1];
	assign rdata2 = (sel2 == reg_pc) ? '0 : regs[sel2];

endmodule

// ==== operand_decode.sv ====
`timescale 1ns/1ps

module operand_decode (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [arm_pkg::word_w-1:0] insn,
	input  logic [arm_pkg::word_w-1:0] pc,
	input  logic [arm_pkg::word_w-1:0] cpsr_in,
	input  logic                       insn_valid,
	output logic [3:0]                 sel0,
	output logic [3:0]                 sel1,
	output logic [3:0]                 sel2,
	input  logic [arm_pkg::word_w-1:0] rdata0,
	input  logic [arm_pkg::word_w-1:0] rdata1,
	input  logic [arm_pkg::word_w-1:0] rdata2,
	output logic [arm_pkg::word_w-1:0] op0,
	output logic [arm_pkg::word_w-1:0] op1,
	output logic [arm_pkg::word_w-1:0] op2,
	output logic [arm_pkg::word_w-1:0] cpsr_out,
	output arm_pkg::insn_class_t       insn_class,
	output logic                       op_valid
);
	import arm_pkg::*;

	insn_class_t       cls;
	logic              pc_far;      // Register-specified shift reads PC + 12.
	logic [word_w-1:0] pc_read;
	logic [word_w-1:0] rn_val;
	logic [word_w-1:0] rm_val;
	logic [4:0]        rot_amt;
	logic [word_w-1:0] imm_ext;
	logic [word_w-1:0] imm_rot;
	logic [word_w-1:0] shift_res;
	logic              shift_carry;
	logic [word_w-1:0] op1_next;
	logic [word_w-1:0] cpsr_next;

	////////////////////////////////////////
	// Classification
	////////////////////////////////////////

	// First match wins.
	always_comb begin
		if (insn[27:22] == 6'b000000 && insn[7:4] == 4'b1001) begin
			cls = class_mul;
		end else if ((insn[27:25] == 3'b000 && insn[7] && insn[4]) ||
		             (insn[27:26] == 2'b00 && insn[24:23] == 2'b10 && !insn[20]) ||
		             (insn[27:25] == 3'b011 && insn[4])) begin
			cls = class_other;  // Halfword, swap, PSR transfer, BX, undefined.
		end else if (insn[27:26] == 2'b00) begin
			cls = class_data;
		end else if (insn[27:26] == 2'b01) begin
			cls = class_sdt;
		end else if (insn[27:25] == 3'b100) begin
			cls = class_bdt;
		end else if (insn[27:25] == 3'b101) begin
			cls = class_branch;
		end else begin
			cls = class_other;  // Coprocessor and SWI.
		end
	end

	// Register selects.
	assign sel0 = (cls == class_mul) ? insn[15:12] : insn[19:16];
	assign sel1 = insn[3:0];
	assign sel2 = insn[11:8];

	assign pc_far  = (cls == class_data) && !insn[25] && insn[4];
	assign pc_read = pc + (pc_far ? 32'd12 : 32'd8);
	assign rn_val  = (sel0 == reg_pc) ? pc_read : rdata0;
	assign rm_val  = (sel1 == reg_pc) ? pc_read : rdata1;

	////////////////////////////////////////
	// Operand 2
	////////////////////////////////////////

	assign imm_ext = {24'b0, insn[7:0]};
	assign rot_amt = {insn[11:8], 1'b0};
	assign imm_rot = (imm_ext >> rot_amt) | (imm_ext << (6'd32 - {1'b0, rot_amt}));

	barrel_shifter u_shifter (
		.operand     (rm_val),
		.reg_amount  (rdata2[7:0]),
		.imm_amount  (insn[11:7]),
		.by_register (insn[4]),
		.shift_type  (shift_type_t'(insn[6:5])),
		.carry_in    (cpsr_in[cpsr_c_bit]),
		.result      (shift_res),
		.carry_out   (shift_carry)
	);

	always_comb begin
		op1_next  = rm_val;  // Multiply and other take Rm as is.
		cpsr_next = cpsr_in;
		case (cls)
			class_data: begin
				if (insn[25]) begin
					op1_next = imm_rot;
				end else begin
					op1_next = shift_res;
					cpsr_next[cpsr_c_bit] = shift_carry;
				end
			end
			class_sdt: begin
				// I bit is inverted for transfers, set means register offset.
				if (insn[25]) begin
					op1_next = shift_res;
					cpsr_next[cpsr_c_bit] = shift_carry;
				end else begin
					op1_next = {20'b0, insn[11:0]};
				end
			end
			class_bdt:    op1_next = {16'b0, insn[15:0]};         // Register list.
			class_branch: op1_next = {{6{insn[23]}}, insn[23:0], 2'b00};
			default:      op1_next = rm_val;
		endcase
	end

	////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op0        <= '0;
			op1        <= '0;
			op2        <= '0;
			cpsr_out   <= '0;
			insn_class <= class_other;
			op_valid   <= 1'b0;
		end else begin
			op_valid <= insn_valid;
			if (insn_valid) begin  // Hold on idle cycles.
				op0        <= rn_val;
				op1        <= op1_next;
				op2        <= rdata2;
				cpsr_out   <= cpsr_next;
				insn_class <= cls;
			end
		end
	end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [arm_pkg::word_w-1:0] insn,
	input  logic [arm_pkg::word_w-1:0] pc,
	input  logic [arm_pkg::word_w-1:0] cpsr_in,
	input  logic                       insn_valid,
	input  logic                       reg_we,
	input  logic [3:0]                 reg_waddr,
	input  logic [arm_pkg::word_w-1:0] reg_wdata,
	output logic [arm_pkg::word_w-1:0] op0,
	output logic [arm_pkg::word_w-1:0] op1,
	output logic [arm_pkg::word_w-1:0] op2,
	output logic [arm_pkg::word_w-1:0] cpsr_out,
	output arm_pkg::insn_class_t       insn_class,
	output logic                       op_valid
);
	import arm_pkg::*;

	// Private read ports, one per operand.
	logic [3:0]        sel0;
	logic [3:0]        sel1;
	logic [3:0]        sel2;
	logic [word_w-1:0] rdata0;
	logic [word_w-1:0] rdata1;
	logic [word_w-1:0] rdata2;

	register_file u_regfile (
		.clk    (clk),
		.rst_n  (rst_n),
		.we     (reg_we),     // Write-back stand-in.
		.waddr  (reg_waddr),
		.wdata  (reg_wdata),
		.sel0   (sel0),
		.sel1   (sel1),
		.sel2   (sel2),
		.rdata0 (rdata0),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	operand_decode u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.insn       (insn),
		.pc         (pc),
		.cpsr_in    (cpsr_in),
		.insn_valid (insn_valid),
		.sel0       (sel0),
		.sel1       (sel1),
		.sel2       (sel2),
		.rdata0     (rdata0),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.op0        (op0),
		.op1        (op1),
		.op2        (op2),
		.cpsr_out   (cpsr_out),
		.insn_class (insn_class),
		.op_valid   (op_valid)
	);

endmodule

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;
	import arm_pkg::*;

	typedef struct packed {
		logic [31:0] op0;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] cpsr;
		logic [2:0]  cls;
	} result_t;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [31:0] insn;
	logic [31:0] pc;
	logic [31:0] cpsr_in;
	logic        insn_valid;
	logic        reg_we;
	logic [3:0]  reg_waddr;
	logic [31:0] reg_wdata;
	logic [31:0] op0;
	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] cpsr_out;
	insn_class_t insn_class;
	logic        op_valid;

	logic [31:0] shadow [0:15] = '{default: '0};  // r15 entry stays zero.
	result_t     exp_q [$];
	string       name_q [$];
	int          reg_amts [8] = '{0, 1, 9, 31, 32, 33, 100, 255};

	decode_stage u_dut (.*);

	always #10 clk = ~clk;

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "Stopping at first error.");
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// One bit per step, so the 32 and above cases fall out of the loop.
	function automatic logic [32:0] shift_ref(logic [31:0] v, logic [1:0] typ, int amt,
	                                          logic by_reg, logic cin);
		logic [31:0] r;
		logic        c;
		r = v;
		c = cin;
		if (!by_reg && amt == 0 && typ == shift_ror) begin
			return {v[0], cin, v[31:1]};  // RRX.
		end
		if (!by_reg && amt == 0 && typ != shift_lsl) begin
			amt = 32;
		end
		for (int k = 0; k < amt; k++) begin
			case (typ)
				shift_lsl: {c, r} = {r, 1'b0};
				shift_lsr: {r, c} = {1'b0, r};
				shift_asr: {r, c} = {r[31], r};
				default:   {r, c} = {r[0], r};
			endcase
		end
		return {c, r};
	endfunction

	function automatic result_t decode_ref(logic [31:0] i, logic [31:0] p, logic [31:0] c);
		result_t     e;
		logic        is_mul;
		logic        is_other;
		logic [3:0]  rn;
		logic [31:0] pc_val;
		logic [31:0] rm;
		logic [32:0] sh;
		is_mul   = i[27:22] == 6'd0 && i[7:4] == 4'b1001;
		is_other = (i[27:25] == 3'b000 && i[7] && i[4]) ||
		           (i[27:26] == 2'b00 && i[24:23] == 2'b10 && !i[20]) ||
		           (i[27:25] == 3'b011 && i[4]);
		case (1'b1)
			is_mul:              e.cls = class_mul;
			is_other:            e.cls = class_other;
			i[27:26] == 2'b00:   e.cls = class_data;
			i[27:26] == 2'b01:   e.cls = class_sdt;
			i[27:25] == 3'b100:  e.cls = class_bdt;
			i[27:25] == 3'b101:  e.cls = class_branch;
			default:             e.cls = class_other;
		endcase
		pc_val = p + ((e.cls == class_data && !i[25] && i[4]) ? 32'd12 : 32'd8);
		rn     = (e.cls == class_mul) ? i[15:12] : i[19:16];
		e.op0  = (rn == 4'd15) ? pc_val : shadow[rn];
		rm     = (i[3:0] == 4'd15) ? pc_val : shadow[i[3:0]];
		e.op2  = shadow[i[11:8]];
		e.op1  = rm;
		e.cpsr = c;
		sh = shift_ref(rm, i[6:5], i[4] ? int'(e.op2[7:0]) : int'(i[11:7]), i[4], c[cpsr_c_bit]);
		if ((e.cls == class_data && !i[25]) || (e.cls == class_sdt && i[25])) begin
			e.op1 = sh[31:0];
			e.cpsr[cpsr_c_bit] = sh[32];
		end else if (e.cls == class_data) begin
			sh    = shift_ref({24'd0, i[7:0]}, shift_ror, int'(i[11:8]) * 2, 1'b1, 1'b0);
			e.op1 = sh[31:0];
		end else if (e.cls == class_sdt) begin
			e.op1 = {20'd0, i[11:0]};
		end else if (e.cls == class_bdt) begin
			e.op1 = {16'd0, i[15:0]};
		end else if (e.cls == class_branch) begin
			e.op1 = {{8{i[23]}}, i[23:0]} << 2;
		end
		return e;
	endfunction

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// ADD into r1, shifted by immediate or by Rs.
	function automatic logic [31:0] dp_insn(logic [3:0] rn, logic [3:0] rm, logic [4:0] amt,
	                                        logic [1:0] typ, logic by_reg);
		if (by_reg) begin
			return {12'he08, rn, 4'h1, amt[3:0], 1'b0, typ, 1'b1, rm};
		end
		return {12'he08, rn, 4'h1, amt, typ, 1'b0, rm};
	endfunction

	task automatic issue(string name, logic [31:0] word, logic [31:0] addr, logic [31:0] status);
		insn       = word;
		pc         = addr;
		cpsr_in    = status;
		insn_valid = 1'b1;
		exp_q.push_back(decode_ref(word, addr, status));
		name_q.push_back(name);
		@(negedge clk);
		insn_valid = 1'b0;
		insn       = $urandom();  // Junk while idle.
		pc         = $urandom();
		cpsr_in    = $urandom();
	endtask

	task automatic write_reg(logic [3:0] addr, logic [31:0] data);
		reg_we    = 1'b1;
		reg_waddr = addr;
		reg_wdata = data;
		@(negedge clk);
		reg_we = 1'b0;
		if (addr != 4'd15) begin
			shadow[addr] = data;
		end
	endtask

	// Outputs load at the rising edge and are compared at the next falling edge.
	initial begin
		result_t last;
		result_t want;
		string   name;
		logic    sent;
		last     = '0;
		last.cls = class_other;  // Reset value.
		forever begin
			@(posedge clk);
			sent = insn_valid;  // Instruction taken at this edge.
			@(negedge clk);
			want = last;
			name = "idle hold";
			if (sent) begin
				want = exp_q.pop_front();
				name = name_q.pop_front();
			end
			check({name, " valid"}, 32'(sent), 32'(op_valid));
			check({name, " op0"}, want.op0, op0);
			check({name, " op1"}, want.op1, op1);
			check({name, " op2"}, want.op2, op2);
			check({name, " cpsr"}, want.cpsr, cpsr_out);
			check({name, " class"}, 32'(want.cls), 32'(insn_class));
			last = want;
		end
	end

	initial begin
		void'($urandom(32'hf090_2960));
		rst_n      = 1'b0;
		insn       = '0;
		pc         = '0;
		cpsr_in    = '0;
		insn_valid = 1'b0;
		reg_we     = 1'b0;
		reg_waddr  = '0;
		reg_wdata  = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		repeat (3) @(negedge clk);

		// Fill r0 to r14. The r15 write goes nowhere.
		for (int k = 0; k < 16; k++) begin
			write_reg(4'(k), $urandom());
		end
		for (int k = 0; k < 24; k++) begin
			issue("regs", dp_insn(4'($urandom()), 4'($urandom()), 5'($urandom()),
			      2'($urandom()), 1'($urandom())), $urandom() & 32'hffff_fffc, $urandom());
		end
		reg_we    = 1'b1;  // Write lands at the same edge as the decode.
		reg_waddr = 4'd3;
		reg_wdata = $urandom();
		issue("write same cycle", dp_insn(4'd3, 4'd3, 5'd3, shift_lsl, 1'b1), 32'h100, '0);
		reg_we    = 1'b0;
		shadow[3] = reg_wdata;
		issue("write next cycle", dp_insn(4'd3, 4'd3, 5'd3, shift_lsl, 1'b1), 32'h104, '0);

		for (int k = 0; k < 16; k++) begin
			issue("rot imm", {12'he28, 4'($urandom()), 4'h1, 4'(k), 8'($urandom())},
			      32'h8000, $urandom());
		end

		// Every immediate amount, then register amounts incl. 0, 32 and up.
		for (int t = 0; t < 4; t++) begin
			write_reg(4'd1, $urandom());
			for (int a = 0; a < 32; a++) begin
				issue("shift imm", dp_insn(4'($urandom()), 4'd1, 5'(a), 2'(t), 1'b0),
				      32'h200, $urandom());
			end
			for (int k = 0; k < 8; k++) begin
				write_reg(4'd2, {24'($urandom()), 8'(reg_amts[k])});
				issue("shift reg", dp_insn(4'($urandom()), 4'd1, 5'd2, 2'(t), 1'b1),
				      32'h300, $urandom());
			end
		end

		issue("pc imm shift", dp_insn(4'd15, 4'd15, 5'd4, shift_lsl, 1'b0), 32'h1000, '0);
		issue("pc reg shift", dp_insn(4'd15, 4'd15, 5'd2, shift_lsr, 1'b1), 32'h2000, '0);
		issue("pc rs r15", dp_insn(4'd15, 4'd15, 5'd15, shift_ror, 1'b1), 32'h3000, $urandom());

		// Remaining classes back to back.
		issue("sdt imm", {12'he59, 4'd4, 4'd1, 12'($urandom())}, 32'h400, $urandom());
		issue("sdt reg", {12'he79, 4'd4, 4'd1, 5'd3, shift_asr, 1'b0, 4'd5}, 32'h404, $urandom());
		issue("bdt", {12'he89, 4'd13, 16'($urandom())}, 32'h408, $urandom());
		issue("branch fwd", {8'hea, 24'h00_0123}, 32'h40c, $urandom());
		issue("branch back", {8'heb, 24'hff_fff0}, 32'h410, $urandom());
		issue("mul", {12'he02, 4'd6, 4'd7, 4'd8, 4'h9, 4'd9}, 32'h414, $urandom());
		issue("swap", {12'he10, 4'd2, 4'd3, 8'h09, 4'd4}, 32'h418, $urandom());
		issue("mrs", 32'he10f_0000, 32'h41c, $urandom());
		issue("halfword", 32'he1d2_30b4, 32'h420, $urandom());
		issue("undefined", 32'he7f0_00f0, 32'h424, $urandom());
		issue("coproc", 32'hee01_2f15, 32'h428, $urandom());
		issue("swi", 32'hef00_0010, 32'h42c, $urandom());

		for (int k = 0; k < 20 && exp_q.size() != 0; k++) begin
			@(negedge clk);
		end
		if (exp_q.size() != 0) begin
			$display("Timed out waiting for %0d decoded results", exp_q.size());
			$display("TESTS FAILED");
			$fatal(1, "Timeout.");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
arm_pkg.sv
barrel_shifter.sv
register_file.sv
operand_decode.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Makefile ====
# Verilator simulation of the decode stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
